/* hdl/lsu_pkg.sv */
package lsu_pkg;

    localparam int VADDR_W = 32;
    localparam int XLEN    = 32;
    // wrap bit on top of five index bits
    localparam int ROB_W   = 6;
    localparam int EXC_W   = 4;
    localparam int SIZE_W  = 2;

    localparam logic [EXC_W-1:0] EXC_NONE = 4'd0;
    localparam logic [EXC_W-1:0] EXC_LAM  = 4'd4;
    localparam logic [EXC_W-1:0] EXC_SAM  = 4'd6;

    // memory word, read whole and written per byte lane
    typedef union packed {
        logic [XLEN-1:0]         word;
        logic [XLEN/8-1:0][7:0]  bytes;
    } mem_word_u;

    // true when a is older than b
    function automatic logic rob_older(
        input logic [ROB_W-1:0] a,
        input logic [ROB_W-1:0] b
    );
        logic same_wrap;
        same_wrap = (a[ROB_W-1] == b[ROB_W-1]);
        if (same_wrap) begin
            return a[ROB_W-2:0] < b[ROB_W-2:0];
        end
        // one side has wrapped, so the larger index was issued first
        return a[ROB_W-2:0] > b[ROB_W-2:0];
    endfunction

endpackage

/* hdl/lsu_access_if.sv */
`timescale 1ns/1ps

interface lsu_access_if;
    import lsu_pkg::*;

    logic                valid;
    logic [VADDR_W-1:0]  vaddr;
    logic [SIZE_W-1:0]   size;
    logic [XLEN/8-1:0]   mask;
    logic [ROB_W-1:0]    rob;
    logic                misalign;

    // address stage drives the stage-1 registers
    modport src(output valid, vaddr, size, mask, rob, misalign);

    // data memory only needs the lane view
    modport mem(input valid, vaddr, mask, misalign);

    modport mon(input valid, vaddr, size, mask, rob, misalign);

endinterface

/* hdl/lsu_addr_stage.sv */
`timescale 1ns/1ps

module lsu_addr_stage (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       valid_i,
    input  logic [lsu_pkg::VADDR_W-1:0] base_i,
    input  logic [lsu_pkg::VADDR_W-1:0] imm_i,
    input  logic [lsu_pkg::SIZE_W-1:0]  size_i,
    input  logic [lsu_pkg::ROB_W-1:0]   rob_i,
    lsu_access_if.src                  acc
);
    import lsu_pkg::*;

    logic [VADDR_W-1:0] vaddr;
    logic [1:0]         offset;
    logic [XLEN/8-1:0]  mask;
    logic               misalign;

    assign vaddr  = base_i + imm_i;
    assign offset = vaddr[1:0];

    always_comb begin
        case (size_i)
            2'd2: begin
                mask     = 4'b1111;
                misalign = |offset;
            end
            2'd1: begin
                // odd offset 3 leaves only the top lane
                mask     = 4'b0011 << offset;
                misalign = offset[0];
            end
            default: begin
                mask     = 4'b0001 << offset;
                misalign = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            acc.valid <= 1'b0;
        end else begin
            acc.valid <= valid_i;
        end
    end

    always_ff @(posedge clk) begin
        acc.vaddr    <= vaddr;
        acc.size     <= size_i;
        acc.mask     <= mask;
        acc.rob      <= rob_i;
        acc.misalign <= misalign;
    end

endmodule

/* hdl/lsu_data_ram.sv */
`timescale 1ns/1ps

module lsu_data_ram #(
    parameter int ADDR_BITS = 6
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [lsu_pkg::XLEN-1:0] store_data_i,
    lsu_access_if.mem               ld,
    lsu_access_if.mem               st,
    output lsu_pkg::mem_word_u      rdata_o
);
    import lsu_pkg::*;

    mem_word_u             mem [2**ADDR_BITS];
    logic [XLEN-1:0]       sdata_q;
    mem_word_u             st_wdata;
    logic [ADDR_BITS-1:0]  st_idx;
    logic [ADDR_BITS-1:0]  ld_idx;
    logic                  st_we;

    // upper address bits alias onto the same words
    assign st_idx = st.vaddr[ADDR_BITS+1:2];
    assign ld_idx = ld.vaddr[ADDR_BITS+1:2];

    // move store data onto the lanes of its offset
    assign st_wdata.word = sdata_q << {st.vaddr[1:0], 3'b000};
    assign st_we         = st.valid & ~st.misalign & ~rst;

    always_ff @(posedge clk) begin
        sdata_q <= store_data_i;
    end

    always_ff @(posedge clk) begin
        if (st_we) begin
            for (int i = 0; i < XLEN/8; i++) begin
                if (st.mask[i]) begin
                    mem[st_idx].bytes[i] <= st_wdata.bytes[i];
                end
            end
        end
    end

    // same-edge store is not visible here
    always_ff @(posedge clk) begin
        if (ld.valid && !ld.misalign) begin
            rdata_o <= mem[ld_idx];
        end
    end

endmodule

/* hdl/lsu_load_align.sv */
`timescale 1ns/1ps

module lsu_load_align (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     uext_i,
    input  lsu_pkg::mem_word_u       rdata_i,
    lsu_access_if.mon                ld,
    output logic                     wb_valid_o,
    output logic [lsu_pkg::XLEN-1:0]  wb_data_o,
    output logic [lsu_pkg::ROB_W-1:0] wb_rob_o,
    output logic [lsu_pkg::EXC_W-1:0] wb_exc_o
);
    import lsu_pkg::*;

    logic              uext_q1;
    logic              uext_q2;
    logic              valid_q;
    logic [1:0]        off_q;
    logic [SIZE_W-1:0] size_q;
    logic [ROB_W-1:0]  rob_q;
    logic              misalign_q;
    logic [XLEN-1:0]   shifted;
    logic [XLEN-1:0]   ext_data;

    // uext comes with the issue, the rest from stage 1
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q    <= 1'b0;
            wb_valid_o <= 1'b0;
        end else begin
            valid_q    <= ld.valid;
            wb_valid_o <= valid_q;
        end
    end

    always_ff @(posedge clk) begin
        uext_q1    <= uext_i;
        uext_q2    <= uext_q1;
        off_q      <= ld.vaddr[1:0];
        size_q     <= ld.size;
        rob_q      <= ld.rob;
        misalign_q <= ld.misalign;
    end

    assign shifted = rdata_i.word >> {off_q, 3'b000};

    always_comb begin
        case (size_q)
            2'd0:    ext_data = {{(XLEN-8){~uext_q2 & shifted[7]}}, shifted[7:0]};
            2'd1:    ext_data = {{(XLEN-16){~uext_q2 & shifted[15]}}, shifted[15:0]};
            default: ext_data = shifted;
        endcase
    end

    always_ff @(posedge clk) begin
        wb_rob_o  <= rob_q;
        wb_data_o <= misalign_q ? '0 : ext_data;
        wb_exc_o  <= misalign_q ? EXC_LAM : EXC_NONE;
    end

endmodule

/* hdl/lsu_exc_tracker.sv */
`timescale 1ns/1ps

module lsu_exc_tracker (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       redirect_i,
    input  logic [lsu_pkg::ROB_W-1:0]   redirect_rob_i,
    lsu_access_if.mon                  ld,
    lsu_access_if.mon                  st,
    output logic                       exc_valid_o,
    output logic [lsu_pkg::ROB_W-1:0]   exc_rob_o,
    output logic [lsu_pkg::EXC_W-1:0]   exc_code_o,
    output logic [lsu_pkg::VADDR_W-1:0] exc_vaddr_o
);
    import lsu_pkg::*;

    logic               ld_cand;
    logic               st_cand;
    logic               pick_ld;
    logic               cand_valid;
    logic [ROB_W-1:0]   cand_rob;
    logic [EXC_W-1:0]   cand_code;
    logic [VADDR_W-1:0] cand_vaddr;
    logic               flush_hit;
    logic               take;

    assign ld_cand = ld.valid & ld.misalign;
    assign st_cand = st.valid & st.misalign;

    // load wins when the store is absent or younger
    assign pick_ld    = ld_cand & (~st_cand | rob_older(ld.rob, st.rob));
    assign cand_valid = ld_cand | st_cand;
    assign cand_rob   = pick_ld ? ld.rob : st.rob;
    assign cand_code  = pick_ld ? EXC_LAM : EXC_SAM;
    assign cand_vaddr = pick_ld ? ld.vaddr : st.vaddr;

    // redirect at or before the held index
    assign flush_hit = redirect_i & ((exc_rob_o == redirect_rob_i) |
                                     rob_older(redirect_rob_i, exc_rob_o));
    assign take      = cand_valid & (~exc_valid_o | rob_older(cand_rob, exc_rob_o));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exc_valid_o <= 1'b0;
        end else if (flush_hit) begin
            exc_valid_o <= 1'b0;
        end else if (take) begin
            exc_valid_o <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!flush_hit && take) begin
            exc_rob_o   <= cand_rob;
            exc_code_o  <= cand_code;
            exc_vaddr_o <= cand_vaddr;
        end
    end

endmodule

/* hdl/lsu_top.sv */
`timescale 1ns/1ps

module lsu_top #(
    parameter int ADDR_BITS = 6
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        load_valid_i,
    input  logic [lsu_pkg::VADDR_W-1:0] load_base_i,
    input  logic [lsu_pkg::VADDR_W-1:0] load_imm_i,
    input  logic [lsu_pkg::SIZE_W-1:0]  load_size_i,
    input  logic                        load_uext_i,
    input  logic [lsu_pkg::ROB_W-1:0]   load_rob_i,
    input  logic                        store_valid_i,
    input  logic [lsu_pkg::VADDR_W-1:0] store_base_i,
    input  logic [lsu_pkg::VADDR_W-1:0] store_imm_i,
    input  logic [lsu_pkg::SIZE_W-1:0]  store_size_i,
    input  logic [lsu_pkg::XLEN-1:0]    store_data_i,
    input  logic [lsu_pkg::ROB_W-1:0]   store_rob_i,
    input  logic                        redirect_i,
    input  logic [lsu_pkg::ROB_W-1:0]   redirect_rob_i,
    output logic                        load_wb_valid_o,
    output logic [lsu_pkg::XLEN-1:0]    load_wb_data_o,
    output logic [lsu_pkg::ROB_W-1:0]   load_wb_rob_o,
    output logic [lsu_pkg::EXC_W-1:0]   load_wb_exc_o,
    output logic                        exc_valid_o,
    output logic [lsu_pkg::ROB_W-1:0]   exc_rob_o,
    output logic [lsu_pkg::EXC_W-1:0]   exc_code_o,
    output logic [lsu_pkg::VADDR_W-1:0] exc_vaddr_o
);
    import lsu_pkg::*;

    mem_word_u rdata;

    lsu_access_if ld_acc();
    lsu_access_if st_acc();

    lsu_addr_stage load_addr (
        .clk     (clk),
        .rst     (rst),
        .valid_i (load_valid_i),
        .base_i  (load_base_i),
        .imm_i   (load_imm_i),
        .size_i  (load_size_i),
        .rob_i   (load_rob_i),
        .acc     (ld_acc.src)
    );

    lsu_addr_stage store_addr (
        .clk     (clk),
        .rst     (rst),
        .valid_i (store_valid_i),
        .base_i  (store_base_i),
        .imm_i   (store_imm_i),
        .size_i  (store_size_i),
        .rob_i   (store_rob_i),
        .acc     (st_acc.src)
    );

    lsu_data_ram #(
        .ADDR_BITS (ADDR_BITS)
    ) data_ram (
        .clk          (clk),
        .rst          (rst),
        .store_data_i (store_data_i),
        .ld           (ld_acc.mem),
        .st           (st_acc.mem),
        .rdata_o      (rdata)
    );

    lsu_load_align load_align (
        .clk        (clk),
        .rst        (rst),
        .uext_i     (load_uext_i),
        .rdata_i    (rdata),
        .ld         (ld_acc.mon),
        .wb_valid_o (load_wb_valid_o),
        .wb_data_o  (load_wb_data_o),
        .wb_rob_o   (load_wb_rob_o),
        .wb_exc_o   (load_wb_exc_o)
    );

    lsu_exc_tracker exc_tracker (
        .clk            (clk),
        .rst            (rst),
        .redirect_i     (redirect_i),
        .redirect_rob_i (redirect_rob_i),
        .ld             (ld_acc.mon),
        .st             (st_acc.mon),
        .exc_valid_o    (exc_valid_o),
        .exc_rob_o      (exc_rob_o),
        .exc_code_o     (exc_code_o),
        .exc_vaddr_o    (exc_vaddr_o)
    );

endmodule

/* tests/lsu_chk.sv */
`timescale 1ns/1ps

module lsu_chk (
    input logic                        clk,
    input logic                        rst,
    input logic                        load_valid_i,
    input logic                        load_wb_valid_o,
    input logic                        exc_valid_o,
    input logic [lsu_pkg::EXC_W-1:0]   exc_code_o
);
    import lsu_pkg::*;

    wb_idle_in_reset: assert property (@(posedge clk) rst |-> !load_wb_valid_o)
        else $error("load writeback valid while in reset");

    // every load comes back three cycles later, and nothing else does
    wb_after_issue: assert property (@(posedge clk) disable iff (rst)
        load_valid_i |-> ##3 load_wb_valid_o)
        else $error("load writeback missing three cycles after issue");

    wb_has_issue: assert property (@(posedge clk) disable iff (rst)
        load_wb_valid_o |-> $past(load_valid_i, 3))
        else $error("load writeback without a load issued three cycles before");

    exc_code_known: assert property (@(posedge clk) disable iff (rst)
        exc_valid_o |-> (exc_code_o == EXC_LAM || exc_code_o == EXC_SAM))
        else $error("held exception has an unknown code");

endmodule

/* tests/tb_lsu.sv */
`timescale 1ns/1ps

module tb_lsu;
    import lsu_pkg::*;

    localparam int ADDR_BITS  = 6;
    localparam int MEM_BYTES  = 4 * (2**ADDR_BITS);
    localparam int MAX_CYCLES = 3000;

    logic clk = 1'b0;
    logic rst;
    logic load_valid_i, load_uext_i, store_valid_i, redirect_i;
    logic load_wb_valid_o, exc_valid_o;
    logic [VADDR_W-1:0] load_base_i, load_imm_i, store_base_i, store_imm_i, exc_vaddr_o;
    logic [SIZE_W-1:0]  load_size_i, store_size_i;
    logic [XLEN-1:0]    store_data_i, load_wb_data_o;
    logic [ROB_W-1:0]   load_rob_i, store_rob_i, redirect_rob_i, load_wb_rob_o, exc_rob_o;
    logic [EXC_W-1:0]   load_wb_exc_o, exc_code_o;

    logic [7:0]         ref_mem [MEM_BYTES];
    logic [XLEN-1:0]    exp_data [$];
    logic [ROB_W-1:0]   exp_rob [$];
    logic [EXC_W-1:0]   exp_exc [$];
    logic               rx_valid;
    logic [ROB_W-1:0]   rx_rob;
    logic [EXC_W-1:0]   rx_code;
    logic [VADDR_W-1:0] rx_vaddr;
    logic [ROB_W-1:0]   next_rob;
    logic               st_before_ld;
    int                 errors = 0;
    int                 checks = 0;
    int                 cycles = 0;
    integer             seed = 32'h726a_b9b2;

    always #5 clk = ~clk;

    lsu_top #(.ADDR_BITS(ADDR_BITS)) dut0 (.*);
    bind lsu_top lsu_chk chk0 (.*);

    function automatic logic misaligned(input logic [VADDR_W-1:0] a, input logic [SIZE_W-1:0] s);
        return (s == 2'd2) ? (a[1:0] != 2'd0) : (s == 2'd1) ? a[0] : 1'b0;
    endfunction

    // wrap bits differ means the larger index was issued earlier
    function automatic logic age_before(input logic [ROB_W-1:0] a, input logic [ROB_W-1:0] b);
        if (a[ROB_W-1] != b[ROB_W-1]) begin
            return a[ROB_W-2:0] > b[ROB_W-2:0];
        end
        return a[ROB_W-2:0] < b[ROB_W-2:0];
    endfunction

    function automatic logic [XLEN-1:0] ref_load(input logic [VADDR_W-1:0] a,
                                                 input logic [SIZE_W-1:0] s, input logic uext);
        int              i;
        logic [XLEN-1:0] v;
        i = int'(a[ADDR_BITS+1:0]);
        if (misaligned(a, s)) begin
            return '0;
        end
        v = {ref_mem[(i+3) % MEM_BYTES], ref_mem[(i+2) % MEM_BYTES],
             ref_mem[(i+1) % MEM_BYTES], ref_mem[i]};
        case (s)
            2'd0:    return uext ? {24'h0, v[7:0]} : {{24{v[7]}}, v[7:0]};
            2'd1:    return uext ? {16'h0, v[15:0]} : {{16{v[15]}}, v[15:0]};
            default: return v;
        endcase
    endfunction

    task automatic note_exc(input logic [ROB_W-1:0] r, input logic [EXC_W-1:0] c,
                            input logic [VADDR_W-1:0] a);
        if (!rx_valid || age_before(r, rx_rob)) begin
            rx_valid = 1'b1;
            rx_rob   = r;
            rx_code  = c;
            rx_vaddr = a;
        end
    endtask

    task automatic check_data(input string name, input logic [XLEN-1:0] exp,
                              input logic [XLEN-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_rob(input string name, input logic [ROB_W-1:0] exp,
                             input logic [ROB_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_exc(input string name, input logic [EXC_W-1:0] exp,
                             input logic [EXC_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("error %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_state();
        check_bit("exc valid", rx_valid, exc_valid_o);
        if (rx_valid && exc_valid_o) begin
            check_rob("exc rob", rx_rob, exc_rob_o);
            check_exc("exc code", rx_code, exc_code_o);
            check_data("exc vaddr", rx_vaddr, exc_vaddr_o);
        end
    endtask

    // inputs hold their values until the next operation
    task automatic run_op(input logic ld_en, input logic [VADDR_W-1:0] ld_addr,
                          input logic [SIZE_W-1:0] ld_size, input logic uext,
                          input logic st_en, input logic [VADDR_W-1:0] st_addr,
                          input logic [SIZE_W-1:0] st_size, input logic [XLEN-1:0] data);
        logic             ld_bad;
        logic             st_bad;
        logic [ROB_W-1:0] st_rob;
        st_rob = st_before_ld ? next_rob - 6'd1 : next_rob + 6'd1;
        ld_bad = ld_en && misaligned(ld_addr, ld_size);
        st_bad = st_en && misaligned(st_addr, st_size);
        @(negedge clk);
        load_valid_i  = ld_en;
        load_imm_i    = $random(seed);
        load_base_i   = ld_addr - load_imm_i;
        load_size_i   = ld_size;
        load_uext_i   = uext;
        load_rob_i    = next_rob;
        store_valid_i = st_en;
        store_imm_i   = $random(seed);
        store_base_i  = st_addr - store_imm_i;
        store_size_i  = st_size;
        store_data_i  = data;
        store_rob_i   = st_rob;
        if (ld_en) begin
            exp_data.push_back(ref_load(ld_addr, ld_size, uext));
            exp_rob.push_back(next_rob);
            exp_exc.push_back(ld_bad ? EXC_LAM : EXC_NONE);
        end
        // only the older of a misaligned pair competes for the record
        if (ld_bad && (!st_bad || age_before(next_rob, st_rob))) begin
            note_exc(next_rob, EXC_LAM, ld_addr);
        end else if (st_bad) begin
            note_exc(st_rob, EXC_SAM, st_addr);
        end
        if (st_en && !st_bad) begin
            for (int k = 0; k < (1 << st_size); k++) begin
                ref_mem[(int'(st_addr[ADDR_BITS+1:0]) + k) % MEM_BYTES] = data[8*k +: 8];
            end
        end
        next_rob = next_rob + 6'd2;
        @(negedge clk);
        load_valid_i  = 1'b0;
        store_valid_i = 1'b0;
        repeat (2) @(negedge clk);
        check_state();
    endtask

    task automatic redirect(input logic [ROB_W-1:0] r);
        @(negedge clk);
        redirect_i     = 1'b1;
        redirect_rob_i = r;
        if (rx_valid && (rx_rob == r || age_before(r, rx_rob))) begin
            rx_valid = 1'b0;
        end
        @(negedge clk);
        redirect_i = 1'b0;
        check_state();
    endtask

    always @(negedge clk) begin
        if (!rst && load_wb_valid_o) begin
            if (exp_data.size() == 0) begin
                errors++;
                $display("load writeback arrived with no load outstanding");
            end else begin
                check_data("load data", exp_data.pop_front(), load_wb_data_o);
                check_rob("load rob", exp_rob.pop_front(), load_wb_rob_o);
                check_exc("load exc", exp_exc.pop_front(), load_wb_exc_o);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run stopped by timeout after %0d cycles", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    initial begin
        logic [VADDR_W-1:0] a1;
        logic [VADDR_W-1:0] a2;
        logic [XLEN-1:0]    d;
        int                 kind;
        rst = 1'b1;
        load_valid_i = 1'b0;
        load_uext_i = 1'b0;
        load_base_i = '0;
        load_imm_i = '0;
        load_size_i = '0;
        load_rob_i = '0;
        store_valid_i = 1'b0;
        store_base_i = '0;
        store_imm_i = '0;
        store_size_i = '0;
        store_data_i = '0;
        store_rob_i = '0;
        redirect_i = 1'b0;
        redirect_rob_i = '0;
        rx_valid = 1'b0;
        next_rob = '0;
        st_before_ld = 1'b0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // fill every word so later loads see known data
        for (int w = 0; w < 2**ADDR_BITS; w++) begin
            run_op(1'b0, 32'h0, 2'd0, 1'b0, 1'b1, w * 4, 2'd2, $random(seed));
        end
        for (int n = 0; n < 8; n++) begin
            a1 = $random(seed);
            a1[1:0] = 2'b00;
            run_op(1'b0, 32'h0, 2'd0, 1'b0, 1'b1, a1, 2'd2, $random(seed));
            run_op(1'b1, a1, 2'd2, 1'b0, 1'b0, 32'h0, 2'd0, 32'h0);
        end
        // load and store on the same word in one cycle
        for (int n = 0; n < 4; n++) begin
            a1 = $random(seed);
            a1[1:0] = 2'b00;
            run_op(1'b1, a1, 2'd2, 1'b0, 1'b1, a1, 2'd2, $random(seed));
        end

        // older store across wrap replaces the held load
        next_rob = 6'h02;
        run_op(1'b1, 32'h101, 2'd2, 1'b0, 1'b0, 32'h0, 2'd0, 32'h0);
        next_rob = 6'h3d;
        run_op(1'b0, 32'h0, 2'd0, 1'b0, 1'b1, 32'h203, 2'd1, 32'hdead_beef);
        redirect(6'h04);
        redirect(6'h3e);
        run_op(1'b1, 32'h200, 2'd2, 1'b0, 1'b0, 32'h0, 2'd0, 32'h0);

        for (int n = 0; n < 300; n++) begin
            kind = {$random(seed)} % 8;
            next_rob = 6'($random(seed));
            a1 = $random(seed);
            a2 = $random(seed);
            d = $random(seed);
            // paired ops sometimes give the store the older index
            st_before_ld = (kind == 7) && d[2];
            if (kind < 3) begin
                run_op(1'b0, a1, 2'd0, 1'b0, 1'b1, a2, 2'({$random(seed)} % 3), d);
            end else if (kind < 6) begin
                run_op(1'b1, a1, 2'({$random(seed)} % 3), d[0], 1'b0, a2, 2'd0, d);
            end else if (kind == 6) begin
                redirect(6'($random(seed)));
            end else begin
                run_op(1'b1, a1, 2'({$random(seed)} % 3), d[1], 1'b1, a2,
                       2'({$random(seed)} % 3), d);
            end
        end

        repeat (6) @(negedge clk);
        if (exp_data.size() != 0) begin
            errors++;
            $display("%0d load writebacks never arrived", exp_data.size());
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* lsu_lite.f */
hdl/lsu_pkg.sv
hdl/lsu_access_if.sv
hdl/lsu_addr_stage.sv
hdl/lsu_data_ram.sv
hdl/lsu_load_align.sv
hdl/lsu_exc_tracker.sv
hdl/lsu_top.sv
tests/lsu_chk.sv
tests/tb_lsu.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_lsu -f lsu_lite.f -o tb_lsu_sim
out=$(./obj_dir/tb_lsu_sim)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1
